//--- fbc_uart_pkg.sv
// serial timing and byte types
package fbc_uart_pkg;

	// one data byte on the serial line
	typedef logic [7:0] uart_byte_t;

	// clocks per serial bit, same width as uart_cpd
	typedef logic [9:0] bit_div_t;

	// silence that ends a message, counted in bit periods
	typedef logic [9:0] spacing_t;

	// wire-outs ep20 and ep21 carry at most four bytes
	localparam int MAX_MSG_BYTES = 4;

	// receiver fsm
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// transmitter fsm
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

//--- fbc_host_pkg.sv
// host wire words and register fields
package fbc_host_pkg;

	// one host wire-in or wire-out word
	typedef logic [15:0] host_word_t;

	// bytes in a finished message, 0 to 4
	typedef logic [2:0] msg_len_t;

	// wrapping event counter
	typedef logic [7:0] count_t;

	// status word ep23, bt_state sits in the top bit
	localparam int STATUS_BT_STATE_BIT = 15;

endpackage

//--- uart_rx.sv
// serial byte receiver
`timescale 1ns/1ps

module uart_rx (
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   rxd,
	input  fbc_uart_pkg::bit_div_t uart_cpd,
	output fbc_uart_pkg::uart_byte_t rx_byte,
	output logic                   rx_valid,
	output logic                   rx_error,
	output logic                   busy
);
	import fbc_uart_pkg::*;

	rx_state_t  state;
	bit_div_t   cnt;
	logic [2:0] bit_idx;
	uart_byte_t shift_q;
	// two flops against metastability on the async line
	logic       rxd_meta;
	logic       rxd_sync;

	always_ff @(posedge clock) begin
		if (rst) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			state <= RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			// strobes last one cycle
			rx_valid <= 1'b0;
			rx_error <= 1'b0;
			cnt <= cnt + bit_div_t'(1);
			case (state)
				RX_IDLE: begin
					// falling edge of start bit
					cnt <= '0;
					if (!rxd_sync)
						state <= RX_START;
				end
				RX_START: begin
					// middle of start bit, drop glitches
					if (cnt == (uart_cpd >> 1)) begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rxd_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (cnt == uart_cpd - bit_div_t'(1)) begin
						cnt <= '0;
						// lsb first
						shift_q <= {rxd_sync, shift_q[7:1]};
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (cnt == uart_cpd - bit_div_t'(1)) begin
						// low stop bit means framing error, byte dropped
						rx_valid <= rxd_sync;
						rx_error <= !rxd_sync;
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// shift register is complete while rx_valid is high
	assign rx_byte = shift_q;
	assign busy = (state != RX_IDLE);

	// mid-bit sampling needs at least two clocks per bit
	a_cpd_min: assert property (@(posedge clock) disable iff (rst)
		uart_cpd >= bit_div_t'(2));

endmodule

//--- msg_framer.sv
// byte to message framer
`timescale 1ns/1ps

module msg_framer #(
	parameter int MSG_BYTES = fbc_uart_pkg::MAX_MSG_BYTES
) (
	input  logic                     clock,
	input  logic                     rst,
	input  fbc_uart_pkg::bit_div_t   uart_cpd,
	input  fbc_uart_pkg::spacing_t   uart_spacing_limit,
	input  fbc_uart_pkg::uart_byte_t rx_byte,
	input  logic                     rx_valid,
	output logic [8*MSG_BYTES-1:0]   msg_data,
	output fbc_host_pkg::msg_len_t   msg_len,
	output logic                     msg_done
);
	import fbc_uart_pkg::*;
	import fbc_host_pkg::*;

	localparam int IDX_W = (MSG_BYTES > 1) ? $clog2(MSG_BYTES) : 1;

	if (MSG_BYTES < 1 || MSG_BYTES > MAX_MSG_BYTES)
		$error("MSG_BYTES out of range");

	uart_byte_t       buf_q [MSG_BYTES];
	msg_len_t         fill;
	// silence timer, clocks inside a bit and whole bits
	bit_div_t         cyc_cnt;
	spacing_t         gap_bits;
	logic             close;
	logic [IDX_W-1:0] wr_idx;

	// full closes without waiting, else close on long enough silence
	assign close = (fill == msg_len_t'(MSG_BYTES)) ||
		((fill != '0) && (gap_bits == uart_spacing_limit));
	// byte landing on a close starts the next message at slot 0
	assign wr_idx = close ? '0 : fill[IDX_W-1:0];

	always_ff @(posedge clock) begin
		if (rx_valid)
			buf_q[wr_idx] <= rx_byte;
		// snapshot so a new byte cannot disturb the closed one
		if (close) begin
			for (int i = 0; i < MSG_BYTES; i++)
				msg_data[8*i +: 8] <= buf_q[i];
			msg_len <= fill;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			fill <= '0;
			cyc_cnt <= '0;
			gap_bits <= '0;
			msg_done <= 1'b0;
		end else begin
			msg_done <= close;
			if (close)
				fill <= rx_valid ? msg_len_t'(1) : '0;
			else if (rx_valid)
				fill <= fill + msg_len_t'(1);
			// restart silence count on every byte
			if (rx_valid) begin
				cyc_cnt <= '0;
				gap_bits <= '0;
			end else if (gap_bits != uart_spacing_limit) begin
				// saturates at the limit
				if (cyc_cnt == uart_cpd - bit_div_t'(1)) begin
					cyc_cnt <= '0;
					gap_bits <= gap_bits + spacing_t'(1);
				end else begin
					cyc_cnt <= cyc_cnt + bit_div_t'(1);
				end
			end
		end
	end

	// closed message is never empty and never overfull
	a_len_range: assert property (@(posedge clock) disable iff (rst)
		msg_done |-> (msg_len != '0) && (msg_len <= msg_len_t'(MSG_BYTES)));

endmodule

//--- ep_out_bank.sv
// host wire-out register bank
`timescale 1ns/1ps

module ep_out_bank #(
	parameter int MSG_BYTES = fbc_uart_pkg::MAX_MSG_BYTES
) (
	input  logic                     clock,
	input  logic                     rst,
	input  logic [8*MSG_BYTES-1:0]   msg_data,
	input  fbc_host_pkg::msg_len_t   msg_len,
	input  logic                     msg_done,
	input  logic                     rx_error,
	input  logic                     rx_busy,
	input  logic                     bt_state,
	output fbc_host_pkg::host_word_t ep20_wire_out,
	output fbc_host_pkg::host_word_t ep21_wire_out,
	output fbc_host_pkg::host_word_t ep22_wire_out,
	output fbc_host_pkg::host_word_t ep23_wire_out,
	output fbc_host_pkg::host_word_t ep25_wire_out
);
	import fbc_uart_pkg::*;
	import fbc_host_pkg::*;

	// busy flag just below bt_state
	localparam int RX_BUSY_BIT = STATUS_BT_STATE_BIT - 1;

	uart_byte_t [MAX_MSG_BYTES-1:0] msg_word;
	count_t                         msg_cnt;
	count_t                         err_cnt;
	host_word_t                     status;

	// bytes past the length or past MSG_BYTES read zero
	always_comb begin
		msg_word = '0;
		for (int i = 0; i < MSG_BYTES; i++)
			if (msg_len > msg_len_t'(i))
				msg_word[i] = msg_data[8*i +: 8];
	end

	always_comb begin
		status = {8'h00, err_cnt};
		status[STATUS_BT_STATE_BIT] = bt_state;
		status[RX_BUSY_BIT] = rx_busy;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			msg_cnt <= '0;
			err_cnt <= '0;
			ep20_wire_out <= '0;
			ep21_wire_out <= '0;
			ep22_wire_out <= '0;
			ep23_wire_out <= '0;
			ep25_wire_out <= '0;
		end else begin
			if (rx_error)
				err_cnt <= err_cnt + count_t'(1);
			// status follows the live levels each cycle
			ep23_wire_out <= status;
			if (msg_done) begin
				msg_cnt <= msg_cnt + count_t'(1);
				ep20_wire_out <= {msg_word[1], msg_word[0]};
				ep21_wire_out <= {msg_word[3], msg_word[2]};
				ep22_wire_out <= {5'd0, msg_len, msg_cnt + count_t'(1)};
				ep25_wire_out <= {8'h00, msg_cnt + count_t'(1)};
			end
		end
	end

endmodule

//--- uart_tx.sv
// serial byte transmitter
`timescale 1ns/1ps

module uart_tx (
	input  logic                     clock,
	input  logic                     rst,
	input  fbc_uart_pkg::bit_div_t   uart_cpd,
	input  fbc_uart_pkg::uart_byte_t tx_data,
	input  logic                     tx_go,
	output logic                     txd
);
	import fbc_uart_pkg::*;

	tx_state_t  state;
	bit_div_t   cnt;
	logic [2:0] bit_idx;
	uart_byte_t shift_q;
	logic       go_q;
	logic       bit_end;

	assign bit_end = (cnt == uart_cpd - bit_div_t'(1));

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= TX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			go_q <= 1'b0;
			txd <= 1'b1;
		end else begin
			// host level, edge found here
			go_q <= tx_go;
			cnt <= bit_end ? '0 : cnt + bit_div_t'(1);
			case (state)
				TX_IDLE: begin
					cnt <= '0;
					// edges while busy are ignored
					if (tx_go && !go_q) begin
						shift_q <= tx_data;
						txd <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						// lsb out first
						txd <= shift_q[0];
						bit_idx <= '0;
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						shift_q <= shift_q >> 1;
						bit_idx <= bit_idx + 3'd1;
						txd <= (bit_idx == 3'd7) ? 1'b1 : shift_q[1];
						if (bit_idx == 3'd7)
							state <= TX_STOP;
					end
				end
				TX_STOP: begin
					// stop bit already high
					if (bit_end)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// line rests high between frames
	a_idle_high: assert property (@(posedge clock) disable iff (rst)
		(state == TX_IDLE) |-> txd);

endmodule

//--- fbc_link.sv
// bluetooth to host link top
`timescale 1ns/1ps

module fbc_link #(
	parameter int MSG_BYTES = fbc_uart_pkg::MAX_MSG_BYTES
) (
	input  logic                     clock,
	input  logic                     rst,
	input  logic                     bt_state,
	input  logic                     bt_txd,
	output logic                     bt_rxd,
	output logic [7:0]               lights,
	input  fbc_uart_pkg::bit_div_t   uart_cpd,
	input  fbc_uart_pkg::spacing_t   uart_spacing_limit,
	input  fbc_host_pkg::host_word_t ep01_wire_in,
	input  fbc_host_pkg::host_word_t ep02_wire_in,
	output fbc_host_pkg::host_word_t ep20_wire_out,
	output fbc_host_pkg::host_word_t ep21_wire_out,
	output fbc_host_pkg::host_word_t ep22_wire_out,
	output fbc_host_pkg::host_word_t ep23_wire_out,
	output fbc_host_pkg::host_word_t ep25_wire_out
);
	import fbc_uart_pkg::*;
	import fbc_host_pkg::*;

	uart_byte_t           rx_byte;
	logic                 rx_valid;
	logic                 rx_error;
	logic                 rx_busy;
	logic [8*MSG_BYTES-1:0] msg_data;
	msg_len_t             msg_len;
	logic                 msg_done;

	// bt module transmits into our receiver
	uart_rx u_rx (
		.clock(clock),
		.rst(rst),
		.rxd(bt_txd),
		.uart_cpd(uart_cpd),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.rx_error(rx_error),
		.busy(rx_busy)
	);

	msg_framer #(.MSG_BYTES(MSG_BYTES)) u_framer (
		.clock(clock),
		.rst(rst),
		.uart_cpd(uart_cpd),
		.uart_spacing_limit(uart_spacing_limit),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.msg_data(msg_data),
		.msg_len(msg_len),
		.msg_done(msg_done)
	);

	ep_out_bank #(.MSG_BYTES(MSG_BYTES)) u_bank (
		.clock(clock),
		.rst(rst),
		.msg_data(msg_data),
		.msg_len(msg_len),
		.msg_done(msg_done),
		.rx_error(rx_error),
		.rx_busy(rx_busy),
		.bt_state(bt_state),
		.ep20_wire_out(ep20_wire_out),
		.ep21_wire_out(ep21_wire_out),
		.ep22_wire_out(ep22_wire_out),
		.ep23_wire_out(ep23_wire_out),
		.ep25_wire_out(ep25_wire_out)
	);

	// host byte out to the bt module receive pin
	uart_tx u_tx (
		.clock(clock),
		.rst(rst),
		.uart_cpd(uart_cpd),
		.tx_data(ep01_wire_in[7:0]),
		.tx_go(ep02_wire_in[0]),
		.txd(bt_rxd)
	);

	// leds are active low, show the message count
	assign lights = ~ep25_wire_out[7:0];

endmodule

//--- fbc_link_tb.sv
// link testbench
`timescale 1ns/1ps

module fbc_link_tb;
	import fbc_uart_pkg::*;
	import fbc_host_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int CPD = 8;
	// silence has to outlast one whole ten-bit frame
	localparam int SPACING = 12;
	localparam int MSG_BYTES = 4;
	localparam int FRAME_CYC = 10 * CPD;
	localparam int GAP_CYC = SPACING * CPD;
	// nine frames and three silences, then margin
	localparam int WATCHDOG_NS = (9 * FRAME_CYC + 3 * GAP_CYC + 400) * CLK_PERIOD;

	logic       clock;
	logic       rst;
	logic       bt_state;
	logic       bt_txd;
	logic       bt_rxd;
	logic [7:0] lights;
	bit_div_t   uart_cpd;
	spacing_t   uart_spacing_limit;
	host_word_t ep01_wire_in;
	host_word_t ep02_wire_in;
	host_word_t ep20_wire_out;
	host_word_t ep21_wire_out;
	host_word_t ep22_wire_out;
	host_word_t ep23_wire_out;
	host_word_t ep25_wire_out;

	// model state and bookkeeping
	logic [31:0] rng;
	count_t      exp_count;
	count_t      exp_err;
	logic [7:0]  bytes_q [0:4];
	int          test_num;
	int          test_errs;
	int          tests_failed;
	int          checks_failed;
	bit          changed;

	fbc_link #(.MSG_BYTES(MSG_BYTES)) DUT (
		.clock(clock),
		.rst(rst),
		.bt_state(bt_state),
		.bt_txd(bt_txd),
		.bt_rxd(bt_rxd),
		.lights(lights),
		.uart_cpd(uart_cpd),
		.uart_spacing_limit(uart_spacing_limit),
		.ep01_wire_in(ep01_wire_in),
		.ep02_wire_in(ep02_wire_in),
		.ep20_wire_out(ep20_wire_out),
		.ep21_wire_out(ep21_wire_out),
		.ep22_wire_out(ep22_wire_out),
		.ep23_wire_out(ep23_wire_out),
		.ep25_wire_out(ep25_wire_out)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// inputs move just after the rising edge
	task automatic tick();
		@(posedge clock);
		#1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) tick();
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_byte(output logic [7:0] b);
		rng = xorshift32(rng);
		b = rng[7:0];
	endtask

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("Error at %t: %s expected %h, got %h", $time, name, exp, got);
			test_errs++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("Error at %t: %s", $time, what);
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (test_errs == 0) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			$display("test %0d %s: %0d failed checks", test_num, name, test_errs);
			tests_failed++;
		end
		checks_failed += test_errs;
		test_errs = 0;
	endtask

	// start bit, eight data bits lsb first, then the given stop level
	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, data, 1'b0};
		for (int b = 0; b < 10; b++) begin
			bt_txd = frame[b];
			wait_cycles(CPD);
		end
		bt_txd = 1'b1;
	endtask

	// decode one frame on bt_rxd, every bit must hold for CPD cycles
	task automatic recv_frame(input logic [7:0] exp_byte);
		logic [9:0] bits;
		int waited;
		int width_errs;
		waited = 0;
		width_errs = 0;
		@(negedge clock);
		while (bt_rxd !== 1'b0 && waited < 4 * CPD) begin
			@(negedge clock);
			waited++;
		end
		if (bt_rxd !== 1'b0) begin
			check_true(1'b0, "no start bit on bt_rxd after the host raised go");
		end else begin
			for (int k = 0; k < FRAME_CYC; k++) begin
				if (k > 0)
					@(negedge clock);
				if (k % CPD == 0)
					bits[k / CPD] = bt_rxd;
				else if (bt_rxd !== bits[k / CPD])
					width_errs++;
			end
			check_true(width_errs == 0, "bt_rxd changed inside a bit period");
			check_val("bt_rxd start bit", {15'd0, bits[0]}, 16'h0000);
			check_val("bt_rxd data", {8'h00, bits[8:1]}, {8'h00, exp_byte});
			check_val("bt_rxd stop bit", {15'd0, bits[9]}, 16'h0001);
		end
	endtask

	// low byte of ep22 (count) or ep23 (errors) leaving its old value
	task automatic wait_byte_change(input bit status_word, input logic [7:0] prev,
			input int limit, output bit seen);
		logic [7:0] cur;
		int n;
		n = 0;
		cur = status_word ? ep23_wire_out[7:0] : ep22_wire_out[7:0];
		while (cur == prev && n < limit) begin
			tick();
			n++;
			cur = status_word ? ep23_wire_out[7:0] : ep22_wire_out[7:0];
		end
		seen = (cur != prev);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		$timeformat(-9, 0, " ns", 0);
		clock = 1'b0;
		rst = 1'b1;
		bt_state = 1'b0;
		bt_txd = 1'b1;
		uart_cpd = bit_div_t'(CPD);
		uart_spacing_limit = spacing_t'(SPACING);
		ep01_wire_in = 16'h0000;
		ep02_wire_in = 16'h0000;
		rng = 32'd80;
		exp_count = '0;
		exp_err = '0;
		test_num = 0;
		test_errs = 0;
		tests_failed = 0;
		checks_failed = 0;
		repeat (2) @(posedge clock);
		#1;
		rst = 1'b0;
		tick();

		// idle line, empty wire-outs, dark lights
		check_val("bt_rxd", {15'd0, bt_rxd}, 16'h0001);
		check_val("ep20_wire_out", ep20_wire_out, 16'h0000);
		check_val("ep21_wire_out", ep21_wire_out, 16'h0000);
		check_val("ep22_wire_out", ep22_wire_out, 16'h0000);
		check_val("ep23_wire_out", ep23_wire_out, 16'h0000);
		check_val("ep25_wire_out", ep25_wire_out, 16'h0000);
		check_val("lights", {8'h00, lights}, 16'h00ff);
		end_test("reset values");

		// two bytes closed by silence
		next_byte(bytes_q[0]);
		next_byte(bytes_q[1]);
		send_frame(bytes_q[0], 1'b1);
		send_frame(bytes_q[1], 1'b1);
		wait_byte_change(1'b0, exp_count, GAP_CYC + 2 * CPD, changed);
		check_true(changed, "message count did not change after the silence");
		exp_count = exp_count + 8'd1;
		check_val("ep22_wire_out", ep22_wire_out, {5'd0, 3'd2, exp_count});
		check_val("ep20_wire_out", ep20_wire_out, {bytes_q[1], bytes_q[0]});
		check_val("ep21_wire_out", ep21_wire_out, 16'h0000);
		check_val("ep25_wire_out", ep25_wire_out, {8'h00, exp_count});
		check_val("lights", {8'h00, lights}, {8'h00, ~exp_count});
		end_test("two bytes then silence");

		// full message closes at once, well before the silence limit
		for (int i = 0; i < 4; i++) begin
			next_byte(bytes_q[i]);
			send_frame(bytes_q[i], 1'b1);
		end
		wait_byte_change(1'b0, exp_count, 2 * CPD, changed);
		check_true(changed, "full message did not close without silence");
		exp_count = exp_count + 8'd1;
		check_val("ep22_wire_out", ep22_wire_out, {5'd0, 3'd4, exp_count});
		check_val("ep20_wire_out", ep20_wire_out, {bytes_q[1], bytes_q[0]});
		check_val("ep21_wire_out", ep21_wire_out, {bytes_q[3], bytes_q[2]});
		// fifth byte opens a fresh message
		next_byte(bytes_q[4]);
		send_frame(bytes_q[4], 1'b1);
		wait_byte_change(1'b0, exp_count, GAP_CYC + 2 * CPD, changed);
		check_true(changed, "byte after a full message was never closed");
		exp_count = exp_count + 8'd1;
		check_val("ep22_wire_out", ep22_wire_out, {5'd0, 3'd1, exp_count});
		check_val("ep20_wire_out", ep20_wire_out, {8'h00, bytes_q[4]});
		check_val("ep21_wire_out", ep21_wire_out, 16'h0000);
		end_test("four bytes fill a message");

		// low stop bit, error counted and no message
		next_byte(bytes_q[0]);
		fork
			send_frame(bytes_q[0], 1'b0);
			begin
				// two bit periods in, the receiver is inside the frame
				wait_cycles(2 * CPD);
				check_val("ep23_wire_out[14]", {15'd0, ep23_wire_out[14]}, 16'h0001);
			end
		join
		wait_byte_change(1'b1, exp_err, 2 * CPD, changed);
		check_true(changed, "framing error count did not change");
		exp_err = exp_err + 8'd1;
		check_val("ep23_wire_out[7:0]", {8'h00, ep23_wire_out[7:0]}, {8'h00, exp_err});
		wait_cycles(GAP_CYC + 2 * CPD);
		check_val("ep22_wire_out[7:0]", {8'h00, ep22_wire_out[7:0]}, {8'h00, exp_count});
		end_test("framing error");

		// host byte out on bt_rxd
		next_byte(bytes_q[0]);
		ep01_wire_in = {8'h00, bytes_q[0]};
		fork
			recv_frame(bytes_q[0]);
			begin
				tick();
				ep02_wire_in = 16'h0001;
			end
		join
		tick();
		ep02_wire_in = 16'h0000;
		wait_cycles(2);
		end_test("host byte to bluetooth");

		// status bit tracks the module state pin
		bt_state = 1'b1;
		wait_cycles(2);
		check_val("ep23_wire_out[15]", {15'd0, ep23_wire_out[STATUS_BT_STATE_BIT]}, 16'h0001);
		bt_state = 1'b0;
		wait_cycles(2);
		check_val("ep23_wire_out[15]", {15'd0, ep23_wire_out[STATUS_BT_STATE_BIT]}, 16'h0000);
		end_test("bt_state follow");

		$display("tests run %0d, tests failed %0d, failed checks %0d",
			test_num, tests_failed, checks_failed);
		if (checks_failed == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- vlog.f
fbc_uart_pkg.sv
fbc_host_pkg.sv
uart_rx.sv
msg_framer.sv
ep_out_bank.sv
uart_tx.sv
fbc_link.sv
fbc_link_tb.sv

//--- Makefile
SIM        = verilator
TOP        = fbc_link_tb
FILELIST   = vlog.f
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
